//--- centroid_pkg.sv
/*
 * shared widths, reset values and enums for the eye tracker core
 * register map offsets and divider states
 */
package centroid_pkg;

    // ----------------------------
    // datapath widths
    // ----------------------------
    localparam int pixel_width    = 8;
    localparam int coord_width    = 10;
    localparam int sum_s_width    = 20;
    localparam int sum_m_width    = 28;

    // one divider bit per cycle, counter sized for the moment width
    localparam int div_count_width = $clog2(sum_m_width);

    // ----------------------------
    // apb bus
    // ----------------------------
    localparam int apb_addr_width = 8;
    localparam int apb_data_width = 32;

    // threshold after reset, mid scale
    localparam int threshold_reset = 128;

    // centroid divider FSM
    typedef enum logic [1:0] {
        div_idle,
        div_run,
        div_done
    } div_state_t;

    // register offsets
    typedef enum logic [apb_addr_width-1:0] {
        reg_threshold   = 8'h00,
        reg_status      = 8'h04,
        reg_centroid_x  = 8'h08,
        reg_centroid_y  = 8'h0C,
        reg_pixel_count = 8'h10,
        reg_frame_count = 8'h14
    } reg_addr_t;

endpackage

//--- camera_timing.sv
`timescale 1ns/100ps
/*
 * camera strobe decoding: beat column, line index, frame start and end pulses
 */
module camera_timing (
    input  logic                                 cclk,
    input  logic                                 reset,
    input  logic                                 fval,
    input  logic                                 lval,
    input  logic                                 dval,
    output logic [centroid_pkg::coord_width-1:0] column,
    output logic [centroid_pkg::coord_width-1:0] line,
    output logic                                 pixel_valid,
    output logic                                 frame_start,
    output logic                                 frame_end
);
    import centroid_pkg::*;

    logic                   fval_q;
    logic                   lval_q;
    logic                   beat;
    logic                   line_start;
    logic                   frame_rise;
    // one spare bit so an overlong line shows up instead of wrapping
    logic [coord_width:0]   beat_cnt;
    logic [coord_width:0]   col_now;
    logic [coord_width-1:0] line_cnt;
    logic [coord_width-1:0] line_now;

    assign beat       = fval & lval & dval;
    assign line_start = lval & ~lval_q;
    assign frame_rise = fval & ~fval_q;

    // first beat may land in the same cycle as the line or frame edge
    assign col_now  = line_start ? '0 : beat_cnt;
    assign line_now = frame_rise ? '0 : line_cnt;

    always_ff @(posedge cclk) begin
        if (reset) begin
            fval_q      <= 1'b0;
            lval_q      <= 1'b0;
            pixel_valid <= 1'b0;
            frame_start <= 1'b0;
            frame_end   <= 1'b0;
            beat_cnt    <= '0;
            line_cnt    <= '0;
            column      <= '0;
            line        <= '0;
        end else begin
            fval_q      <= fval;
            lval_q      <= lval;
            pixel_valid <= beat;
            frame_start <= frame_rise;
            frame_end   <= ~fval & fval_q;

            if (beat) begin
                column   <= col_now[coord_width-1:0];
                line     <= line_now;
                beat_cnt <= col_now + 1'b1;
            end else if (line_start) begin
                beat_cnt <= '0;
            end

            // line index steps on each lval fall inside the frame
            if (frame_rise) begin
                line_cnt <= '0;
            end else if (fval && !lval && lval_q) begin
                line_cnt <= line_cnt + 1'b1;
            end
        end
    end

    column_no_wrap: assert property (@(posedge cclk) disable iff (reset)
        beat |-> !col_now[coord_width])
        else $error("camera line longer than the column range");

endmodule

//--- lane_accumulator.sv
`timescale 1ns/100ps
/*
 * one pixel lane: threshold compare and per-frame count, x and y moment sums
 */
module lane_accumulator #(
    parameter int lane = 0
) (
    input  logic                                 cclk,
    input  logic                                 reset,
    input  logic [centroid_pkg::pixel_width-1:0] pixel,
    input  logic [centroid_pkg::pixel_width-1:0] threshold,
    input  logic [centroid_pkg::coord_width-1:0] column,
    input  logic [centroid_pkg::coord_width-1:0] line,
    input  logic                                 pixel_valid,
    input  logic                                 frame_start,
    output logic [centroid_pkg::sum_s_width-1:0] sum_s,
    output logic [centroid_pkg::sum_m_width-1:0] sum_x,
    output logic [centroid_pkg::sum_m_width-1:0] sum_y
);
    import centroid_pkg::*;

    logic                   bright_q;
    logic                   hit;
    logic [coord_width:0]   x_pos;
    logic [sum_s_width-1:0] base_s;
    logic [sum_m_width-1:0] base_x;
    logic [sum_m_width-1:0] base_y;

    // compare is registered to line up with the registered timing strobes
    always_ff @(posedge cclk) begin
        bright_q <= (pixel >= threshold);
    end

    assign hit = pixel_valid & bright_q;

    // left lane holds even columns, right lane odd ones
    assign x_pos = {column, 1'(lane)};

    // a beat arriving with frame_start counts into the new frame
    assign base_s = frame_start ? '0 : sum_s;
    assign base_x = frame_start ? '0 : sum_x;
    assign base_y = frame_start ? '0 : sum_y;

    always_ff @(posedge cclk) begin
        if (reset) begin
            sum_s <= '0;
            sum_x <= '0;
            sum_y <= '0;
        end else if (hit) begin
            sum_s <= base_s + 1'b1;
            sum_x <= base_x + sum_m_width'(x_pos);
            sum_y <= base_y + sum_m_width'(line);
        end else begin
            sum_s <= base_s;
            sum_x <= base_x;
            sum_y <= base_y;
        end
    end

    count_monotonic: assert property (@(posedge cclk) disable iff (reset)
        !frame_start |=> sum_s >= $past(sum_s))
        else $error("lane %0d bright count went down inside a frame", lane);

endmodule

//--- centroid_divider.sv
`timescale 1ns/100ps
/*
 * lane sum merge and two restoring dividers for the x and y centroid
 */
module centroid_divider (
    input  logic                                 cclk,
    input  logic                                 reset,
    input  logic                                 frame_end,
    input  logic [centroid_pkg::sum_s_width-1:0] sum_s_l,
    input  logic [centroid_pkg::sum_m_width-1:0] sum_x_l,
    input  logic [centroid_pkg::sum_m_width-1:0] sum_y_l,
    input  logic [centroid_pkg::sum_s_width-1:0] sum_s_r,
    input  logic [centroid_pkg::sum_m_width-1:0] sum_x_r,
    input  logic [centroid_pkg::sum_m_width-1:0] sum_y_r,
    output logic [centroid_pkg::coord_width-1:0] centroid_x,
    output logic [centroid_pkg::coord_width-1:0] centroid_y,
    output logic [centroid_pkg::sum_s_width-1:0] pixel_count,
    output logic                                 no_target,
    output logic                                 result_done
);
    import centroid_pkg::*;

    div_state_t                 state;
    logic                       start_q;
    logic                       total_zero;
    logic [div_count_width-1:0] bit_cnt;
    logic [sum_s_width-1:0]     total_s;
    logic [sum_m_width-1:0]     total_x;
    logic [sum_m_width-1:0]     total_y;
    logic [sum_s_width-1:0]     count;
    logic [sum_s_width-1:0]     rem_x;
    logic [sum_s_width-1:0]     rem_y;
    logic [sum_m_width-1:0]     quo_x;
    logic [sum_m_width-1:0]     quo_y;

    // one restoring step, dividend bits shift out of quo as quotient bits shift in
    function automatic logic [sum_s_width+sum_m_width-1:0] div_step(
        input logic [sum_s_width-1:0] rem,
        input logic [sum_m_width-1:0] quo,
        input logic [sum_s_width-1:0] divisor
    );
        logic [sum_s_width:0] shifted;
        logic [sum_s_width:0] diff;
        shifted = {rem, quo[sum_m_width-1]};
        diff    = shifted - {1'b0, divisor};
        if (shifted >= {1'b0, divisor}) begin
            return {diff[sum_s_width-1:0], quo[sum_m_width-2:0], 1'b1};
        end
        return {shifted[sum_s_width-1:0], quo[sum_m_width-2:0], 1'b0};
    endfunction

    assign total_s    = sum_s_l + sum_s_r;
    assign total_x    = sum_x_l + sum_x_r;
    assign total_y    = sum_y_l + sum_y_r;
    assign total_zero = (total_s == '0);

    // ----------------------------
    // control FSM
    // ----------------------------
    always_ff @(posedge cclk) begin
        if (reset) begin
            state     <= div_idle;
            start_q   <= 1'b0;
            bit_cnt   <= '0;
            no_target <= 1'b0;
        end else begin
            // frame_end while busy is dropped
            start_q <= frame_end && (state == div_idle);
            case (state)
                div_idle: begin
                    if (start_q) begin
                        no_target <= total_zero;
                        bit_cnt   <= div_count_width'(sum_m_width - 1);
                        state     <= total_zero ? div_done : div_run;
                    end
                end
                div_run: begin
                    bit_cnt <= bit_cnt - 1'b1;
                    if (bit_cnt == '0) begin
                        state <= div_done;
                    end
                end
                default: state <= div_idle;
            endcase
        end
    end

    // ----------------------------
    // shared-counter datapath
    // ----------------------------
    always_ff @(posedge cclk) begin
        if (state == div_idle && start_q) begin
            count <= total_s;
            rem_x <= '0;
            rem_y <= '0;
            quo_x <= total_zero ? '0 : total_x;
            quo_y <= total_zero ? '0 : total_y;
        end else if (state == div_run) begin
            {rem_x, quo_x} <= div_step(rem_x, quo_x, count);
            {rem_y, quo_y} <= div_step(rem_y, quo_y, count);
        end
    end

    assign result_done = (state == div_done);
    assign pixel_count = count;
    assign centroid_x  = quo_x[coord_width-1:0];
    assign centroid_y  = quo_y[coord_width-1:0];

    frame_end_when_idle: assert property (@(posedge cclk) disable iff (reset)
        frame_end |-> (state == div_idle) && !start_q)
        else $error("frame end arrived while the divider was busy");

endmodule

//--- apb_regs.sv
`timescale 1ns/100ps
/*
 * APB register block: threshold, status, frame counter and centroid results
 */
module apb_regs (
    input  logic                                    cclk,
    input  logic                                    reset,
    input  logic                                    psel,
    input  logic                                    penable,
    input  logic                                    pwrite,
    input  logic [centroid_pkg::apb_addr_width-1:0] paddr,
    input  logic [centroid_pkg::apb_data_width-1:0] pwdata,
    output logic [centroid_pkg::apb_data_width-1:0] prdata,
    output logic                                    pready,
    output logic                                    pslverr,
    output logic [centroid_pkg::pixel_width-1:0]    threshold,
    input  logic                                    frame_start,
    input  logic                                    frame_end,
    input  logic [centroid_pkg::coord_width-1:0]    centroid_x,
    input  logic [centroid_pkg::coord_width-1:0]    centroid_y,
    input  logic [centroid_pkg::sum_s_width-1:0]    pixel_count,
    input  logic                                    no_target,
    input  logic                                    result_done
);
    import centroid_pkg::*;

    logic                      access;
    logic                      addr_hit;
    logic                      result_valid;
    logic                      no_target_q;
    logic [coord_width-1:0]    centroid_x_q;
    logic [coord_width-1:0]    centroid_y_q;
    logic [sum_s_width-1:0]    pixel_count_q;
    logic [apb_data_width-1:0] frame_count;

    // no wait states
    assign access  = psel & penable;
    assign pready  = access;
    assign pslverr = access & ~addr_hit;

    // read mux and address decode
    always_comb begin
        addr_hit = 1'b1;
        prdata   = '0;
        case (paddr)
            reg_threshold:   prdata = apb_data_width'(threshold);
            reg_status:      prdata = apb_data_width'({no_target_q, result_valid});
            reg_centroid_x:  prdata = apb_data_width'(centroid_x_q);
            reg_centroid_y:  prdata = apb_data_width'(centroid_y_q);
            reg_pixel_count: prdata = apb_data_width'(pixel_count_q);
            reg_frame_count: prdata = frame_count;
            default:         addr_hit = 1'b0;
        endcase
    end

    always_ff @(posedge cclk) begin
        if (reset) begin
            threshold     <= pixel_width'(threshold_reset);
            result_valid  <= 1'b0;
            no_target_q   <= 1'b0;
            centroid_x_q  <= '0;
            centroid_y_q  <= '0;
            pixel_count_q <= '0;
            frame_count   <= '0;
        end else begin
            if (access && pwrite && paddr == reg_threshold) begin
                threshold <= pwdata[pixel_width-1:0];
            end

            // a finished result wins over a new frame in the same cycle
            if (result_done) begin
                result_valid  <= 1'b1;
                no_target_q   <= no_target;
                centroid_x_q  <= centroid_x;
                centroid_y_q  <= centroid_y;
                pixel_count_q <= pixel_count;
            end else if (frame_start) begin
                result_valid <= 1'b0;
            end

            if (frame_end) begin
                frame_count <= frame_count + 1'b1;
            end
        end
    end

    penable_needs_psel: assert property (@(posedge cclk) disable iff (reset)
        penable |-> psel)
        else $error("apb penable high without psel");

    setup_then_access: assert property (@(posedge cclk) disable iff (reset)
        (psel && !penable) |=> (psel && penable))
        else $error("apb setup phase not followed by access phase");

endmodule

//--- eye_tracker_top.sv
`timescale 1ns/100ps
/*
 * eye tracker core: camera timing, two pixel lanes, centroid divider, APB registers
 */
module eye_tracker_top (
    input  logic                                    cclk,
    input  logic                                    reset,
    input  logic                                    fval,
    input  logic                                    lval,
    input  logic                                    dval,
    input  logic [centroid_pkg::pixel_width-1:0]    data_l,
    input  logic [centroid_pkg::pixel_width-1:0]    data_r,
    input  logic                                    psel,
    input  logic                                    penable,
    input  logic                                    pwrite,
    input  logic [centroid_pkg::apb_addr_width-1:0] paddr,
    input  logic [centroid_pkg::apb_data_width-1:0] pwdata,
    output logic [centroid_pkg::apb_data_width-1:0] prdata,
    output logic                                    pready,
    output logic                                    pslverr
);
    import centroid_pkg::*;

    logic [coord_width-1:0] column;
    logic [coord_width-1:0] line;
    logic                   pixel_valid;
    logic                   frame_start;
    logic                   frame_end;
    logic [pixel_width-1:0] threshold;
    logic [sum_s_width-1:0] sum_s_l;
    logic [sum_s_width-1:0] sum_s_r;
    logic [sum_m_width-1:0] sum_x_l;
    logic [sum_m_width-1:0] sum_x_r;
    logic [sum_m_width-1:0] sum_y_l;
    logic [sum_m_width-1:0] sum_y_r;
    logic [coord_width-1:0] centroid_x;
    logic [coord_width-1:0] centroid_y;
    logic [sum_s_width-1:0] pixel_count;
    logic                   no_target;
    logic                   result_done;

    camera_timing timing_inst (
        .cclk(cclk), .reset(reset),
        .fval(fval), .lval(lval), .dval(dval),
        .column(column), .line(line), .pixel_valid(pixel_valid),
        .frame_start(frame_start), .frame_end(frame_end)
    );

    // even column lane
    lane_accumulator #(.lane(0)) lane_l_inst (
        .cclk(cclk), .reset(reset), .pixel(data_l), .threshold(threshold),
        .column(column), .line(line), .pixel_valid(pixel_valid), .frame_start(frame_start),
        .sum_s(sum_s_l), .sum_x(sum_x_l), .sum_y(sum_y_l)
    );

    // odd column lane
    lane_accumulator #(.lane(1)) lane_r_inst (
        .cclk(cclk), .reset(reset), .pixel(data_r), .threshold(threshold),
        .column(column), .line(line), .pixel_valid(pixel_valid), .frame_start(frame_start),
        .sum_s(sum_s_r), .sum_x(sum_x_r), .sum_y(sum_y_r)
    );

    centroid_divider divider_inst (
        .cclk(cclk), .reset(reset), .frame_end(frame_end),
        .sum_s_l(sum_s_l), .sum_x_l(sum_x_l), .sum_y_l(sum_y_l),
        .sum_s_r(sum_s_r), .sum_x_r(sum_x_r), .sum_y_r(sum_y_r),
        .centroid_x(centroid_x), .centroid_y(centroid_y), .pixel_count(pixel_count),
        .no_target(no_target), .result_done(result_done)
    );

    apb_regs regs_inst (
        .cclk(cclk), .reset(reset),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
        .prdata(prdata), .pready(pready), .pslverr(pslverr), .threshold(threshold),
        .frame_start(frame_start), .frame_end(frame_end),
        .centroid_x(centroid_x), .centroid_y(centroid_y), .pixel_count(pixel_count),
        .no_target(no_target), .result_done(result_done)
    );

endmodule

//--- tb_ref.svh
/*
 * reference centroid model for the testbench
 * frame image fill helpers for background and rectangles
 */
`ifndef TB_REF_SVH
`define TB_REF_SVH

// ------------------------------
// reference model
// ------------------------------

// bright when the pixel is at least the threshold, centroid truncated
function automatic void ref_centroid(
    input  int thr,
    output int count,
    output int cx,
    output int cy,
    output bit no_target
);
    int sx;
    int sy;
    count = 0;
    sx    = 0;
    sy    = 0;
    for (int y = 0; y < frame_lines; y++) begin
        for (int x = 0; x < frame_width; x++) begin
            if (int'(image[y][x]) >= thr) begin
                count = count + 1;
                sx    = sx + x;
                sy    = sy + y;
            end
        end
    end
    no_target = (count == 0);
    cx        = no_target ? 0 : sx / count;
    cy        = no_target ? 0 : sy / count;
endfunction

// ------------------------------
// image helpers
// ------------------------------

// random values in lo..hi over the whole frame
function automatic void fill_background(input int lo, input int hi);
    for (int y = 0; y < frame_lines; y++) begin
        for (int x = 0; x < frame_width; x++) begin
            image[y][x] = pixel_width'($urandom_range(hi, lo));
        end
    end
endfunction

// rectangle of random values in lo..hi, must fit inside the frame
function automatic void fill_rect(input int x0, input int y0, input int w, input int h,
                                  input int lo, input int hi);
    for (int y = y0; y < y0 + h; y++) begin
        for (int x = x0; x < x0 + w; x++) begin
            image[y][x] = pixel_width'($urandom_range(hi, lo));
        end
    end
endfunction

`endif

//--- tb_eye_tracker.sv
`timescale 1ns/100ps
/*
 * testbench for the eye tracker core: clock, reset, APB and camera drivers,
 * directed and random frame tests, watchdog and summary
 */
module tb_eye_tracker;
    import centroid_pkg::*;

    localparam int clk_period    = 100;
    localparam int frame_beats   = 32;
    localparam int frame_width   = 2 * frame_beats;
    localparam int frame_lines   = 16;
    localparam int line_gap      = 4;
    localparam int random_frames = 10;
    localparam int total_frames  = 3 + random_frames;
    // worst case beats per frame with dval gaps plus divider latency and polling
    localparam int frame_cycles  = frame_lines * (2 * frame_beats + line_gap) + 200;
    localparam int timeout_ns    = total_frames * frame_cycles * 3 * clk_period;

    logic                      cclk;
    logic                      reset;
    logic                      fval;
    logic                      lval;
    logic                      dval;
    logic [pixel_width-1:0]    data_l;
    logic [pixel_width-1:0]    data_r;
    logic                      psel;
    logic                      penable;
    logic                      pwrite;
    logic [apb_addr_width-1:0] paddr;
    logic [apb_data_width-1:0] pwdata;
    logic [apb_data_width-1:0] prdata;
    logic                      pready;
    logic                      pslverr;

    logic [pixel_width-1:0]    image [0:frame_lines-1][0:frame_width-1];
    logic [apb_data_width-1:0] snapshot [0:5];
    reg_addr_t                 map_regs [0:5];
    int                        cur_threshold;
    int                        frames_sent;
    int                        checks;
    int                        errors;
    int                        errors_at_start;
    int                        tests_run;

    `include "tb_ref.svh"

    eye_tracker_top eye_tracker_top_inst (.*);

    initial begin
        cclk = 1'b0;
        forever #(clk_period / 2) cclk = ~cclk;
    end

    // ------------------------------
    // APB driver tasks started on a falling edge
    // ------------------------------
    task automatic read_reg(input logic [apb_addr_width-1:0] addr,
                            output logic [apb_data_width-1:0] data, output bit err);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        @(negedge cclk);
        penable = 1'b1;
        // sample in the middle of the access phase
        #(clk_period / 4);
        data = prdata;
        err  = pslverr;
        check_equal("pready in access phase", 32'(pready), 1);
        @(negedge cclk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic write_reg(input logic [apb_addr_width-1:0] addr,
                             input logic [apb_data_width-1:0] data, output bit err);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(negedge cclk);
        penable = 1'b1;
        #(clk_period / 4);
        err = pslverr;
        check_equal("pready in access phase", 32'(pready), 1);
        @(negedge cclk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic set_threshold(input int value);
        bit err;
        write_reg(reg_threshold, value, err);
        cur_threshold = value;
    endtask

    // ------------------------------
    // camera driver
    // ------------------------------
    task automatic send_frame();
        fval = 1'b1;
        repeat (2) @(negedge cclk);
        for (int y = 0; y < frame_lines; y++) begin
            lval = 1'b1;
            for (int b = 0; b < frame_beats; b++) begin
                // idle beat carries full scale data that must not count
                if ($urandom_range(3) == 0) begin
                    dval   = 1'b0;
                    data_l = '1;
                    data_r = '1;
                    @(negedge cclk);
                end
                dval   = 1'b1;
                data_l = image[y][2*b];
                data_r = image[y][2*b+1];
                @(negedge cclk);
            end
            lval   = 1'b0;
            dval   = 1'b0;
            data_l = '1;
            data_r = '1;
            repeat (line_gap) @(negedge cclk);
        end
        fval        = 1'b0;
        frames_sent = frames_sent + 1;
        repeat (2) @(negedge cclk);
    endtask

    // ------------------------------
    // checking
    // ------------------------------
    task automatic check_equal(input string what, input logic [apb_data_width-1:0] got,
                               input logic [apb_data_width-1:0] exp);
        checks = checks + 1;
        assert (got === exp) else begin
            errors = errors + 1;
            $display("FAIL %0t ns: %s got 0x%0h expected 0x%0h", $time, what, got, exp);
        end
    endtask

    // polls status until the frame result is loaded, then compares it
    task automatic check_frame();
        int                        exp_count;
        int                        exp_x;
        int                        exp_y;
        bit                        exp_none;
        logic [apb_data_width-1:0] data;
        bit                        err;
        ref_centroid(cur_threshold, exp_count, exp_x, exp_y, exp_none);
        data = '0;
        while (data[0] == 1'b0) begin
            read_reg(reg_status, data, err);
        end
        check_equal("no_target flag", 32'(data[1]), 32'(exp_none));
        read_reg(reg_pixel_count, data, err);
        check_equal("pixel count", data, exp_count);
        read_reg(reg_centroid_x, data, err);
        check_equal("centroid x", data, exp_x);
        read_reg(reg_centroid_y, data, err);
        check_equal("centroid y", data, exp_y);
    endtask

    task automatic report_test(input string name);
        tests_run = tests_run + 1;
        if (errors == errors_at_start) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            $display("test %0d %s: %0d errors", tests_run, name, errors - errors_at_start);
        end
        errors_at_start = errors;
    endtask

    // ------------------------------
    // test sequence
    // ------------------------------
    initial begin
        logic [apb_data_width-1:0] data;
        bit                        err;
        void'($urandom(50));
        reset           = 1'b1;
        fval            = 1'b0;
        lval            = 1'b0;
        dval            = 1'b0;
        data_l          = '0;
        data_r          = '0;
        psel            = 1'b0;
        penable         = 1'b0;
        pwrite          = 1'b0;
        paddr           = '0;
        pwdata          = '0;
        cur_threshold   = threshold_reset;
        frames_sent     = 0;
        checks          = 0;
        errors          = 0;
        errors_at_start = 0;
        tests_run       = 0;
        map_regs        = '{reg_threshold, reg_status, reg_centroid_x,
                            reg_centroid_y, reg_pixel_count, reg_frame_count};
        // reset spans two rising edges
        repeat (2) @(posedge cclk);
        @(negedge cclk);
        reset = 1'b0;

        read_reg(reg_threshold, data, err);
        check_equal("threshold after reset", data, threshold_reset);
        read_reg(reg_status, data, err);
        check_equal("status after reset", data, 0);
        read_reg(reg_frame_count, data, err);
        check_equal("frame count after reset", data, 0);
        report_test("reset values");

        fill_background(0, 40);
        fill_rect(10, 3, 8, 5, 200, 255);
        send_frame();
        check_frame();
        report_test("single blob");

        // dimmer second blob starting on an odd column
        fill_rect(41, 9, 7, 4, 90, 110);
        // one pixel exactly at the new threshold
        fill_rect(50, 12, 1, 1, 80, 80);
        set_threshold(80);
        send_frame();
        check_frame();
        report_test("threshold change");

        fill_background(0, 79);
        send_frame();
        check_frame();
        report_test("no target");

        set_threshold(threshold_reset);
        repeat (random_frames) begin
            fill_background(0, 110);
            fill_rect($urandom_range(50), $urandom_range(10),
                      $urandom_range(13, 1), $urandom_range(5, 1), 128, 255);
            send_frame();
            check_frame();
        end
        read_reg(reg_frame_count, data, err);
        check_equal("frame count", data, frames_sent);
        report_test("random frames");

        for (int i = 0; i < 6; i++) begin
            read_reg(map_regs[i], snapshot[i], err);
            check_equal("pslverr on mapped read", 32'(err), 0);
        end
        read_reg(8'h18, data, err);
        check_equal("pslverr on unmapped read", 32'(err), 1);
        write_reg(8'h1C, '1, err);
        check_equal("pslverr on unmapped write", 32'(err), 1);
        write_reg(8'h01, '1, err);
        check_equal("pslverr on unmapped write", 32'(err), 1);
        for (int i = 0; i < 6; i++) begin
            read_reg(map_regs[i], data, err);
            check_equal("register after unmapped write", data, snapshot[i]);
        end
        report_test("unmapped offsets");

        $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    initial begin
        #(timeout_ns);
        $display("watchdog timeout: tests did not finish within %0d ns", timeout_ns);
        $display("TB FAILED");
        $finish;
    end

endmodule

//--- all.f
+incdir+.
centroid_pkg.sv
camera_timing.sv
lane_accumulator.sv
centroid_divider.sv
apb_regs.sv
eye_tracker_top.sv
tb_eye_tracker.sv

//--- Makefile
# Verilator build and run for the eye tracker testbench

VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_eye_tracker
FILELIST  = all.f
OBJ_DIR   = obj_dir

BIN     = $(OBJ_DIR)/V$(TOP)
SOURCES = $(shell grep -v '^+' $(FILELIST)) $(wildcard *.svh)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# status comes from searching the output for the pass line
run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf $(OBJ_DIR)
